// ==== dv/issue_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_properties (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  flush,
    input logic                  full,
    input issue_pkg::occupancy_t occupancy
);

    // nothing enters while full
    // only pops or a flush move occupancy then
    no_growth_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (full && !flush) |=> (occupancy <= $past(occupancy)))
        else $error("occupancy grew to %0d while full", occupancy);

    // at most two entries leave per edge
    // a bank overrun wraps its pointers and shows as a bigger drop
    no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        !flush |=> (int'(occupancy) + 2 >= int'($past(occupancy))))
        else $error("occupancy dropped to %0d without a flush", occupancy);

    // flush pulse resets all pointers
    flush_empties: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> (occupancy == '0))
        else $error("occupancy %0d after flush", occupancy);

endmodule

`default_nettype wire

// ==== dv/issue_tests.svh ====
`ifndef ISSUE_TESTS_SVH
`define ISSUE_TESTS_SVH

// pair pushed, both slots out in the same cycle, then popped
task automatic expect_pair_issue(input issue_pkg::dec_instr_t a,
                                 input issue_pkg::dec_instr_t b, input string what);
    push_pair(a, b);
    wait_for_issue(4);
    check_issued(iss[1], expect_slot(a, 1, 1'b0), what);
    check_issued(iss[0], expect_slot(b, 0, a.is_branch), what);
    check_req(reg_req[1], source_regs(a), what);
    check_req(reg_req[0], source_regs(b), what);
    @(posedge clk);
endtask

// older alone first, younger moves up to slot 1 next cycle
task automatic expect_split_issue(input issue_pkg::dec_instr_t a,
                                  input issue_pkg::dec_instr_t b, input string what);
    push_pair(a, b);
    wait_for_issue(4);
    check_issued(iss[1], expect_slot(a, 1, 1'b0), what);
    check_bit(iss[0].valid, 1'b0, what);
    check_req(reg_req[1], source_regs(a), what);
    check_req(reg_req[0], source_regs(b), what);
    @(posedge clk);
    @(negedge clk);
    check_issued(iss[1], expect_slot(b, 1, 1'b0), what);
    check_bit(iss[0].valid, 1'b0, what);
    check_req(reg_req[1], source_regs(b), what);
    @(posedge clk);
endtask

task automatic reset_defaults();
    @(negedge clk);
    check_bit(iss[1].valid, 1'b0, "slot 1 valid after reset");
    check_bit(iss[0].valid, 1'b0, "slot 2 valid after reset");
    check_bit(full, 1'b0, "full after reset");
    check_bit(apb_rsp.pslverr, 1'b0, "pslverr after reset");
    apb_read(issue_pkg::CTRL_ADDR, 32'h1, 1'b0);
    apb_read(issue_pkg::STATUS_ADDR, 32'h0, 1'b0);
    // unmapped address
    apb_read(8'h10, 32'h0, 1'b1);
endtask

task automatic independent_pairs();
    for (int k = 0; k < 4; k++) begin
        // walks through rf and bypass sources
        load_operands(1'b1, 4'(k * 5));
        expect_pair_issue(new_instr(5'd1, 5'd2, 5'd3, 1'b0, 1'b0, 1'b0),
                          new_instr(5'd4, 5'd5, 5'd6, 1'b0, 1'b0, 1'b0), "independent pair");
    end
    @(negedge clk);
    check_bit(iss[1].valid, 1'b0, "queue empty after pairs");
endtask

task automatic pairing_hazards();
    issue_pkg::dec_instr_t a;
    issue_pkg::dec_instr_t br;
    issue_pkg::dec_instr_t ds;
    issue_pkg::dec_instr_t d;
    load_operands(1'b1, 4'b0110);
    // younger reads r7
    expect_split_issue(new_instr(5'd7, 5'd1, 5'd2, 1'b0, 1'b0, 1'b0),
                       new_instr(5'd8, 5'd7, 5'd3, 1'b0, 1'b0, 1'b0), "dependent pair");
    expect_split_issue(new_instr(5'd9, 5'd1, 5'd2, 1'b0, 1'b1, 1'b0),
                       new_instr(5'd10, 5'd3, 5'd4, 1'b0, 1'b1, 1'b0), "two mul/div");
    expect_split_issue(new_instr(5'd11, 5'd1, 5'd2, 1'b0, 1'b0, 1'b0),
                       new_instr(5'd12, 5'd3, 5'd4, 1'b0, 1'b0, 1'b1), "single issue");
    // slot 2 branch needs its delay slot from the next pair
    a  = new_instr(5'd13, 5'd1, 5'd2, 1'b0, 1'b0, 1'b0);
    br = new_instr(5'd31, 5'd3, 5'd4, 1'b1, 1'b0, 1'b0);
    ds = new_instr(5'd14, 5'd5, 5'd6, 1'b0, 1'b0, 1'b0);
    d  = new_instr(5'd15, 5'd7, 5'd8, 1'b0, 1'b0, 1'b0);
    drive_pair(a, br);
    drive_pair(ds, d);
    wait_for_issue(4);
    check_issued(iss[1], expect_slot(a, 1, 1'b0), "older of branch pair");
    check_bit(iss[0].valid, 1'b0, "branch held from slot 2");
    end_pairs();
    @(negedge clk);
    check_issued(iss[1], expect_slot(br, 1, 1'b0), "branch in slot 1");
    check_issued(iss[0], expect_slot(ds, 0, 1'b1), "delay slot");
    @(posedge clk);
    @(negedge clk);
    check_issued(iss[1], expect_slot(d, 1, 1'b0), "after delay slot");
    check_bit(iss[0].valid, 1'b0, "nothing behind last entry");
    @(posedge clk);
endtask

task automatic branch_delay_slot();
    load_operands(1'b1, 4'b1001);
    // jal writes r31, delay slot reads it
    expect_pair_issue(new_instr(5'd31, 5'd1, 5'd2, 1'b1, 1'b0, 1'b0),
                      new_instr(5'd3, 5'd31, 5'd4, 1'b0, 1'b0, 1'b0), "dependent delay slot");
    apb_write(issue_pkg::CTRL_ADDR, 32'h0, 1'b0);
    apb_read(issue_pkg::CTRL_ADDR, 32'h0, 1'b0);
    expect_split_issue(new_instr(5'd11, 5'd12, 5'd13, 1'b0, 1'b0, 1'b0),
                       new_instr(5'd14, 5'd15, 5'd16, 1'b0, 1'b0, 1'b0), "dual issue off");
    // branch pairs regardless of dual_en
    expect_pair_issue(new_instr(5'd20, 5'd1, 5'd2, 1'b1, 1'b0, 1'b0),
                      new_instr(5'd21, 5'd3, 5'd4, 1'b0, 1'b0, 1'b0), "branch, dual off");
    apb_write(issue_pkg::CTRL_ADDR, 32'h1, 1'b0);
endtask

task automatic overflow_and_flush();
    issue_pkg::word_t cap_word;
    issue_pkg::word_t ovf_word;
    cap_word = issue_pkg::word_t'(issue_pkg::QUEUE_CAP);
    ovf_word = issue_pkg::word_t'(1) << issue_pkg::OVF_ERR_BIT;
    // nothing leaves while operands are missing
    load_operands(1'b0, 4'b0000);
    for (int k = 0; k < issue_pkg::QUEUE_CAP / 2; k++) begin
        drive_pair(new_instr(5'd1, 5'd2, 5'd3, 1'b0, 1'b0, 1'b0),
                   new_instr(5'd4, 5'd5, 5'd6, 1'b0, 1'b0, 1'b0));
    end
    end_pairs();
    @(negedge clk);
    check_bit(full, 1'b1, "full at capacity");
    check_bit(iss[1].valid, 1'b0, "issue without ready operands");
    apb_read(issue_pkg::STATUS_ADDR, cap_word, 1'b0);
    // dropped pair
    push_pair(new_instr(5'd7, 5'd8, 5'd9, 1'b0, 1'b0, 1'b0),
              new_instr(5'd10, 5'd11, 5'd12, 1'b0, 1'b0, 1'b0));
    apb_read(issue_pkg::STATUS_ADDR, cap_word | ovf_word, 1'b0);
    apb_write(issue_pkg::STATUS_ADDR, ovf_word, 1'b0);
    apb_read(issue_pkg::STATUS_ADDR, cap_word, 1'b0);
    // flush with dual_en kept set, queue empty one edge later
    apb_write(issue_pkg::CTRL_ADDR, 32'h3, 1'b0);
    @(posedge clk);
    @(negedge clk);
    check_bit(full, 1'b0, "full after flush");
    check_bit(iss[1].valid, 1'b0, "slot 1 valid after flush");
    apb_read(issue_pkg::STATUS_ADDR, 32'h0, 1'b0);
    apb_read(issue_pkg::CTRL_ADDR, 32'h1, 1'b0);
endtask

task automatic stall_freeze();
    issue_pkg::dec_instr_t a;
    issue_pkg::dec_instr_t b;
    a = new_instr(5'd1, 5'd2, 5'd3, 1'b0, 1'b0, 1'b0);
    b = new_instr(5'd4, 5'd5, 5'd6, 1'b0, 1'b0, 1'b0);
    load_operands(1'b0, 4'b0011);
    push_pair(a, b);
    @(posedge clk);
    stall <= 1'b1;
    load_operands(1'b1, 4'b0011);
    // candidates ready but pinned
    repeat (3) begin
        @(negedge clk);
        check_issued(iss[1], expect_slot(a, 1, 1'b0), "slot 1 under stall");
        check_issued(iss[0], expect_slot(b, 0, 1'b0), "slot 2 under stall");
    end
    push_pair(new_instr(5'd7, 5'd8, 5'd9, 1'b0, 1'b0, 1'b0),
              new_instr(5'd10, 5'd11, 5'd12, 1'b0, 1'b0, 1'b0));
    apb_read(issue_pkg::STATUS_ADDR, 32'd2, 1'b0);
    @(negedge clk);
    check_issued(iss[1], expect_slot(a, 1, 1'b0), "slot 1 after stalled push");
    @(posedge clk);
    stall <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_bit(iss[1].valid, 1'b0, "queue drained after stall");
    apb_read(issue_pkg::STATUS_ADDR, 32'h0, 1'b0);
endtask

`endif

// ==== dv/issue_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_tb;

    // all tests together take a few hundred cycles
    localparam int CYCLE_LIMIT = 2000;

    logic                           clk;
    logic                           rst_n;
    logic                           stall;
    logic                           full;
    issue_pkg::dec_instr_t    [1:0] dec;
    issue_pkg::word_t         [1:0] rf_rd1;
    issue_pkg::word_t         [1:0] rf_rd2;
    issue_pkg::operand_t      [1:0] byp1;
    issue_pkg::operand_t      [1:0] byp2;
    issue_pkg::apb_req_t            apb;
    issue_pkg::apb_rsp_t            apb_rsp;
    issue_pkg::issued_instr_t [1:0] iss;
    issue_pkg::reg_req_t      [1:0] reg_req;

    int cycle_count = 0;
    int check_count = 0;

    issue_top issue_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .dec     (dec),
        .stall   (stall),
        .rf_rd1  (rf_rd1),
        .rf_rd2  (rf_rd2),
        .byp1    (byp1),
        .byp2    (byp2),
        .apb     (apb),
        .iss     (iss),
        .reg_req (reg_req),
        .full    (full),
        .apb_rsp (apb_rsp)
    );

    // queue invariants
    bind issue_queue issue_properties issue_queue_props (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .full      (full),
        .occupancy (occupancy)
    );

    initial clk = 1'b0;
    // 8 ns period
    always #4 clk = ~clk;

    task automatic halt_run();
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout, run went past %0d cycles", CYCLE_LIMIT);
            halt_run();
        end
    end

    task automatic check_issued(input issue_pkg::issued_instr_t got,
                                input issue_pkg::issued_instr_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
            halt_run();
        end
    endtask

    task automatic check_req(input issue_pkg::reg_req_t got, input issue_pkg::reg_req_t exp,
                             input string what);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
            halt_run();
        end
    endtask

    task automatic check_word(input issue_pkg::word_t got, input issue_pkg::word_t exp,
                              input string what);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
            halt_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
            halt_run();
        end
    endtask

    // issued slot as the rules give it, operands from port index s
    function automatic issue_pkg::issued_instr_t expect_slot(input issue_pkg::dec_instr_t d,
                                                             input int s, input logic slot);
        issue_pkg::issued_instr_t e;
        e          = '0;
        e.valid    = 1'b1;
        e.pc       = d.pc;
        e.rdst     = d.rdst;
        e.regwrite = d.regwrite;
        e.rd1      = byp1[s].bypass ? byp1[s].data : rf_rd1[s];
        e.rd2      = byp2[s].bypass ? byp2[s].data : rf_rd2[s];
        e.is_slot  = slot;
        return e;
    endfunction

    // register read request of a queued candidate
    function automatic issue_pkg::reg_req_t source_regs(input issue_pkg::dec_instr_t d);
        issue_pkg::reg_req_t r;
        r.ra1 = d.ra1;
        r.ra2 = d.ra2;
        return r;
    endfunction

    function automatic issue_pkg::dec_instr_t new_instr(input issue_pkg::reg_addr_t rdst,
        input issue_pkg::reg_addr_t ra1, input issue_pkg::reg_addr_t ra2,
        input logic is_branch, input logic is_multi, input logic single_issue);
        issue_pkg::dec_instr_t d;
        d              = '0;
        d.valid        = 1'b1;
        // word aligned random pc
        d.pc           = $urandom & 32'hffff_fffc;
        d.rdst         = rdst;
        d.ra1          = ra1;
        d.ra2          = ra2;
        d.regwrite     = 1'b1;
        d.is_branch    = is_branch;
        d.is_multi     = is_multi;
        d.single_issue = single_issue;
        return d;
    endfunction

    // use_byp bit 2*s is port 1 of slot s, bit 2*s+1 is port 2
    task automatic load_operands(input logic ready, input logic [3:0] use_byp);
        issue_pkg::word_t    [1:0] r1;
        issue_pkg::word_t    [1:0] r2;
        issue_pkg::operand_t [1:0] o1;
        issue_pkg::operand_t [1:0] o2;
        for (int s = 0; s < 2; s++) begin
            r1[s] = $urandom;
            r2[s] = $urandom;
            o1[s] = '{ready: ready, bypass: use_byp[2*s], data: $urandom};
            o2[s] = '{ready: ready, bypass: use_byp[2*s+1], data: $urandom};
        end
        @(posedge clk);
        rf_rd1 <= r1;
        rf_rd2 <= r2;
        byp1   <= o1;
        byp2   <= o2;
    endtask

    task automatic drive_pair(input issue_pkg::dec_instr_t older,
                              input issue_pkg::dec_instr_t younger);
        @(posedge clk);
        dec[1] <= older;
        dec[0] <= younger;
    endtask

    task automatic end_pairs();
        @(posedge clk);
        dec <= '0;
    endtask

    // returns right after the edge that writes the pair
    task automatic push_pair(input issue_pkg::dec_instr_t older,
                             input issue_pkg::dec_instr_t younger);
        drive_pair(older, younger);
        end_pairs();
    endtask

    task automatic wait_for_issue(input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (!iss[1].valid) begin
            if (n >= max_cycles) begin
                $display("no instruction issued within %0d cycles", max_cycles);
                halt_run();
            end
            n++;
            @(negedge clk);
        end
    endtask

    // setup then access phase, write lands on the closing edge
    task automatic apb_access(input logic write, input issue_pkg::apb_addr_t addr,
                              input issue_pkg::word_t wdata, input logic exp_err,
                              output issue_pkg::word_t rdata);
        issue_pkg::apb_req_t req;
        req        = '0;
        req.psel   = 1'b1;
        req.pwrite = write;
        req.paddr  = addr;
        req.pwdata = wdata;
        @(posedge clk);
        apb <= req;
        req.penable = 1'b1;
        @(posedge clk);
        apb <= req;
        @(negedge clk);
        check_bit(apb_rsp.pready, 1'b1, "apb pready");
        check_bit(apb_rsp.pslverr, exp_err, "apb pslverr");
        rdata = apb_rsp.prdata;
        @(posedge clk);
        apb <= '0;
    endtask

    task automatic apb_write(input issue_pkg::apb_addr_t addr, input issue_pkg::word_t data,
                             input logic exp_err);
        issue_pkg::word_t unused;
        apb_access(1'b1, addr, data, exp_err, unused);
    endtask

    task automatic apb_read(input issue_pkg::apb_addr_t addr, input issue_pkg::word_t exp,
                            input logic exp_err);
        issue_pkg::word_t got;
        apb_access(1'b0, addr, '0, exp_err, got);
        check_word(got, exp, "apb read data");
    endtask

    `include "issue_tests.svh"

    initial begin
        void'($urandom(32'he9a3));
        rst_n  <= 1'b0;
        stall  <= 1'b0;
        dec    <= '0;
        rf_rd1 <= '0;
        rf_rd2 <= '0;
        byp1   <= '0;
        byp2   <= '0;
        apb    <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        reset_defaults();
        independent_pairs();
        pairing_hazards();
        branch_delay_slot();
        overflow_and_flush();
        stall_freeze();
        if (check_count > 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("no checks were run");
            halt_run();
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module issue_tb -f verilog.f -o issue_sim \
    && ./obj_dir/issue_sim \
    || exit 1

// ==== source/issue_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_bank (
    input  logic                   clk,
    input  logic                   we,
    input  issue_pkg::bank_ptr_t   waddr,
    input  issue_pkg::dec_instr_t  wdata,
    input  issue_pkg::bank_ptr_t   raddr,
    output issue_pkg::dec_instr_t  rdata
);

    // entry storage, validity tracked by the queue pointers
    issue_pkg::dec_instr_t mem [issue_pkg::BANK_DEPTH];

    // write at tail on the edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // head entry visible in the same cycle
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

// ==== source/issue_csr.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_csr (
    input  logic                  clk,
    input  logic                  rst_n,
    input  issue_pkg::apb_req_t   apb,
    output issue_pkg::apb_rsp_t   apb_rsp,
    input  issue_pkg::occupancy_t occupancy,
    input  logic                  enq_drop,
    output logic                  dual_en,
    output logic                  flush
);

    logic access;
    logic hit_ctrl;
    logic hit_status;
    logic wr_ctrl;
    logic wr_status;
    logic ovf_err;

    // access phase, no wait states
    assign access     = apb.psel & apb.penable;
    assign hit_ctrl   = (apb.paddr == issue_pkg::CTRL_ADDR);
    assign hit_status = (apb.paddr == issue_pkg::STATUS_ADDR);
    assign wr_ctrl    = access & apb.pwrite & hit_ctrl;
    assign wr_status  = access & apb.pwrite & hit_status;

    always_comb begin
        apb_rsp         = '0;
        apb_rsp.pready  = 1'b1;
        // unmapped address errors out
        apb_rsp.pslverr = access & ~hit_ctrl & ~hit_status;
        if (access && !apb.pwrite) begin
            if (hit_ctrl) begin
                // flush bit is write only
                apb_rsp.prdata[issue_pkg::DUAL_EN_BIT] = dual_en;
            end else if (hit_status) begin
                apb_rsp.prdata[$bits(issue_pkg::occupancy_t)-1:0] = occupancy;
                apb_rsp.prdata[issue_pkg::OVF_ERR_BIT]            = ovf_err;
            end
        end
    end

    // ctrl register and flush pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dual_en <= 1'b1;
            flush   <= 1'b0;
        end else begin
            flush <= wr_ctrl & apb.pwdata[issue_pkg::FLUSH_BIT];
            if (wr_ctrl) begin
                dual_en <= apb.pwdata[issue_pkg::DUAL_EN_BIT];
            end
        end
    end

    // sticky overflow, write 1 clears
    // a new drop in the same cycle keeps it set
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ovf_err <= 1'b0;
        end else if (enq_drop) begin
            ovf_err <= 1'b1;
        end else if (wr_status && apb.pwdata[issue_pkg::OVF_ERR_BIT]) begin
            ovf_err <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

    // queue geometry
    localparam int BANK_DEPTH = 16;
    localparam int PTR_W      = $clog2(BANK_DEPTH);
    // one slot per bank stays free so head == tail means empty
    localparam int QUEUE_CAP  = 2 * (BANK_DEPTH - 1);

    // csr map
    localparam logic [7:0] CTRL_ADDR   = 8'h00;
    localparam logic [7:0] STATUS_ADDR = 8'h04;
    localparam int DUAL_EN_BIT = 0;
    localparam int FLUSH_BIT   = 1;
    localparam int OVF_ERR_BIT = 8;

    // widths with meaning
    typedef logic [31:0]      word_t;
    typedef logic [4:0]       reg_addr_t;
    typedef logic [PTR_W-1:0] bank_ptr_t;
    typedef logic [5:0]       occupancy_t;
    typedef logic [7:0]       apb_addr_t;

    // decoded instruction as stored in the queue
    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rdst;
        reg_addr_t ra1;
        reg_addr_t ra2;
        logic      regwrite;
        // branch or jump
        logic      is_branch;
        // mul or div
        logic      is_multi;
        logic      single_issue;
    } dec_instr_t;

    // issued slot with operands resolved
    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rdst;
        logic      regwrite;
        word_t     rd1;
        word_t     rd2;
        // delay slot of a branch issued alongside
        logic      is_slot;
    } issued_instr_t;

    // source registers of one candidate
    typedef struct packed {
        reg_addr_t ra1;
        reg_addr_t ra2;
    } reg_req_t;

    // bypass network answer for one source port
    typedef struct packed {
        logic  ready;
        logic  bypass;
        word_t data;
    } operand_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        word_t     pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// ==== source/issue_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_queue (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stall,
    input  logic                        flush,
    input  issue_pkg::dec_instr_t [1:0] dec,
    input  logic [1:0]                  issue_en,
    output issue_pkg::dec_instr_t [1:0] cand,
    output logic                        full,
    output logic                        enq_drop,
    output issue_pkg::occupancy_t       occupancy
);

    issue_pkg::bank_ptr_t  head_even;
    issue_pkg::bank_ptr_t  head_odd;
    issue_pkg::bank_ptr_t  tail_even;
    issue_pkg::bank_ptr_t  tail_odd;
    issue_pkg::bank_ptr_t  cnt_even;
    issue_pkg::bank_ptr_t  cnt_odd;

    issue_pkg::dec_instr_t even_wdata;
    issue_pkg::dec_instr_t odd_wdata;
    issue_pkg::dec_instr_t even_rdata;
    issue_pkg::dec_instr_t odd_rdata;
    issue_pkg::dec_instr_t first_in;
    issue_pkg::dec_instr_t second_in;

    logic first_vld;
    logic second_vld;
    logic enq_ok;
    logic odd_next;
    logic odd_oldest;
    logic odd_we;
    logic even_we;
    logic pop_odd;
    logic pop_even;
    logic odd_nonempty;
    logic even_nonempty;

    issue_bank even_bank (
        .clk   (clk),
        .we    (even_we),
        .waddr (tail_even),
        .wdata (even_wdata),
        .raddr (head_even),
        .rdata (even_rdata)
    );

    issue_bank odd_bank (
        .clk   (clk),
        .we    (odd_we),
        .waddr (tail_odd),
        .wdata (odd_wdata),
        .raddr (head_odd),
        .rdata (odd_rdata)
    );

    // per bank fill level, pointer difference wraps naturally
    assign cnt_even  = tail_even - head_even;
    assign cnt_odd   = tail_odd - head_odd;
    assign occupancy = issue_pkg::occupancy_t'(cnt_even) + issue_pkg::occupancy_t'(cnt_odd);

    // a pair needs a free slot in each bank
    assign full = (cnt_even == issue_pkg::bank_ptr_t'(issue_pkg::BANK_DEPTH - 1))
               || (cnt_odd == issue_pkg::bank_ptr_t'(issue_pkg::BANK_DEPTH - 1));

    assign enq_ok   = ~stall & ~full;
    // decoder pushed into a full queue
    assign enq_drop = ~stall & full & (dec[1].valid | dec[0].valid);

    // equal tails: odd bank takes the next (older) entry
    assign odd_next = (tail_odd == tail_even);

    always_comb begin
        // compact the pair so a lone younger entry still lands first
        first_vld  = dec[1].valid | dec[0].valid;
        first_in   = dec[1].valid ? dec[1] : dec[0];
        second_vld = dec[1].valid & dec[0].valid;
        second_in  = dec[0];
        // pair always splits across banks
        odd_we     = enq_ok & (odd_next ? first_vld : second_vld);
        odd_wdata  = odd_next ? first_in : second_in;
        even_we    = enq_ok & (odd_next ? second_vld : first_vld);
        even_wdata = odd_next ? second_in : first_in;
    end

    // equal heads: oldest entry sits in the odd bank
    assign odd_oldest    = (head_odd == head_even);
    assign odd_nonempty  = (head_odd != tail_odd);
    assign even_nonempty = (head_even != tail_even);

    // candidate ordering, index 1 oldest
    always_comb begin
        cand = '0;
        if (odd_oldest) begin
            if (odd_nonempty) begin
                cand[1] = odd_rdata;
            end
            if (even_nonempty) begin
                cand[0] = even_rdata;
            end
        end else begin
            if (even_nonempty) begin
                cand[1] = even_rdata;
            end
            if (odd_nonempty) begin
                cand[0] = odd_rdata;
            end
        end
    end

    // map slot enables back onto banks
    assign pop_odd  = ~stall & (odd_oldest ? issue_en[1] : issue_en[0]);
    assign pop_even = ~stall & (odd_oldest ? issue_en[0] : issue_en[1]);

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head_even <= '0;
            head_odd  <= '0;
            tail_even <= '0;
            tail_odd  <= '0;
        end else begin
            if (even_we) begin
                tail_even <= tail_even + issue_pkg::bank_ptr_t'(1);
            end
            if (odd_we) begin
                tail_odd <= tail_odd + issue_pkg::bank_ptr_t'(1);
            end
            if (pop_even) begin
                head_even <= head_even + issue_pkg::bank_ptr_t'(1);
            end
            if (pop_odd) begin
                head_odd <= head_odd + issue_pkg::bank_ptr_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/issue_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_select (
    input  issue_pkg::dec_instr_t    [1:0] cand,
    input  logic                           dual_en,
    input  issue_pkg::word_t         [1:0] rf_rd1,
    input  issue_pkg::word_t         [1:0] rf_rd2,
    input  issue_pkg::operand_t      [1:0] byp1,
    input  issue_pkg::operand_t      [1:0] byp2,
    output logic                     [1:0] issue_en,
    output issue_pkg::issued_instr_t [1:0] iss,
    output issue_pkg::reg_req_t      [1:0] reg_req
);

    issue_pkg::dec_instr_t older;
    issue_pkg::dec_instr_t younger;

    logic ops_ok_old;
    logic ops_ok_young;
    logic raw_dep;
    logic pair_block;
    logic pair_ok;

    // bypass value wins over the register file
    function automatic issue_pkg::word_t pick_operand(issue_pkg::operand_t op,
                                                      issue_pkg::word_t rf);
        return op.bypass ? op.data : rf;
    endfunction

    assign older   = cand[1];
    assign younger = cand[0];

    // both source ports resolved
    assign ops_ok_old   = byp1[1].ready & byp2[1].ready;
    assign ops_ok_young = byp1[0].ready & byp2[0].ready;

    // younger reads what older writes
    assign raw_dep = older.regwrite
                  && ((older.rdst == younger.ra1) || (older.rdst == younger.ra2));

    // branch + delay slot ignores dependence and dual_en
    assign pair_block = younger.is_branch
                     || older.single_issue
                     || younger.single_issue
                     || (older.is_multi && younger.is_multi)
                     || (raw_dep && !older.is_branch)
                     || (!dual_en && !older.is_branch);

    assign pair_ok = younger.valid & ops_ok_young & ~pair_block;

    // branch waits until its delay slot can go too
    assign issue_en[1] = older.valid & ops_ok_old & (~older.is_branch | pair_ok);
    assign issue_en[0] = issue_en[1] & pair_ok;

    always_comb begin
        iss = '0;
        for (int i = 0; i < 2; i++) begin
            // source regs of each candidate go out regardless of issue
            reg_req[i].ra1 = cand[i].ra1;
            reg_req[i].ra2 = cand[i].ra2;
            if (issue_en[i]) begin
                iss[i].valid    = 1'b1;
                iss[i].pc       = cand[i].pc;
                iss[i].rdst     = cand[i].rdst;
                iss[i].regwrite = cand[i].regwrite;
                iss[i].rd1      = pick_operand(byp1[i], rf_rd1[i]);
                iss[i].rd2      = pick_operand(byp2[i], rf_rd2[i]);
            end
        end
        // delay slot marker
        iss[0].is_slot = issue_en[0] & older.is_branch;
    end

endmodule

`default_nettype wire

// ==== source/issue_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  issue_pkg::dec_instr_t    [1:0] dec,
    input  logic                           stall,
    input  issue_pkg::word_t         [1:0] rf_rd1,
    input  issue_pkg::word_t         [1:0] rf_rd2,
    input  issue_pkg::operand_t      [1:0] byp1,
    input  issue_pkg::operand_t      [1:0] byp2,
    input  issue_pkg::apb_req_t            apb,
    output issue_pkg::issued_instr_t [1:0] iss,
    output issue_pkg::reg_req_t      [1:0] reg_req,
    output logic                           full,
    output issue_pkg::apb_rsp_t            apb_rsp
);

    issue_pkg::dec_instr_t [1:0] cand;
    issue_pkg::occupancy_t       occupancy;
    logic [1:0]                  issue_en;
    logic                        enq_drop;
    logic                        dual_en;
    logic                        flush;

    // banked instruction queue
    issue_queue issue_queue_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .flush     (flush),
        .dec       (dec),
        .issue_en  (issue_en),
        .cand      (cand),
        .full      (full),
        .enq_drop  (enq_drop),
        .occupancy (occupancy)
    );

    // pairing check and operand mux
    issue_select issue_select_i (
        .cand     (cand),
        .dual_en  (dual_en),
        .rf_rd1   (rf_rd1),
        .rf_rd2   (rf_rd2),
        .byp1     (byp1),
        .byp2     (byp2),
        .issue_en (issue_en),
        .iss      (iss),
        .reg_req  (reg_req)
    );

    // apb control and status
    issue_csr issue_csr_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb       (apb),
        .apb_rsp   (apb_rsp),
        .occupancy (occupancy),
        .enq_drop  (enq_drop),
        .dual_en   (dual_en),
        .flush     (flush)
    );

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+dv
source/issue_pkg.sv
source/issue_bank.sv
source/issue_queue.sv
source/issue_select.sv
source/issue_csr.sv
source/issue_top.sv
dv/issue_properties.sv
dv/issue_tb.sv
